/* include/hex_font.svh */
//----------------------------------------------------------------------
// 8x8 glyphs for the hex digits 0 to F, row 0 at the top
// bit 7 of each row byte is the leftmost pixel
// include inside a module body to get the hex_font table
//----------------------------------------------------------------------

// indexed as hex_font[digit][row]
localparam logic [7:0] hex_font [16][8] = '{
    '{8'h3c, 8'h66, 8'h6e, 8'h76, 8'h66, 8'h66, 8'h3c, 8'h00},  // 0
    '{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7e, 8'h00},  // 1
    '{8'h3c, 8'h66, 8'h06, 8'h0c, 8'h30, 8'h60, 8'h7e, 8'h00},  // 2
    '{8'h3c, 8'h66, 8'h06, 8'h1c, 8'h06, 8'h66, 8'h3c, 8'h00},  // 3
    '{8'h0c, 8'h1c, 8'h3c, 8'h6c, 8'h7e, 8'h0c, 8'h0c, 8'h00},  // 4
    '{8'h7e, 8'h60, 8'h7c, 8'h06, 8'h06, 8'h66, 8'h3c, 8'h00},  // 5
    '{8'h3c, 8'h60, 8'h60, 8'h7c, 8'h66, 8'h66, 8'h3c, 8'h00},  // 6
    '{8'h7e, 8'h06, 8'h0c, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00},  // 7
    '{8'h3c, 8'h66, 8'h66, 8'h3c, 8'h66, 8'h66, 8'h3c, 8'h00},  // 8
    '{8'h3c, 8'h66, 8'h66, 8'h3e, 8'h06, 8'h0c, 8'h38, 8'h00},  // 9
    '{8'h18, 8'h3c, 8'h66, 8'h66, 8'h7e, 8'h66, 8'h66, 8'h00},  // a
    '{8'h7c, 8'h66, 8'h66, 8'h7c, 8'h66, 8'h66, 8'h7c, 8'h00},  // b
    '{8'h3c, 8'h66, 8'h60, 8'h60, 8'h60, 8'h66, 8'h3c, 8'h00},  // c
    '{8'h78, 8'h6c, 8'h66, 8'h66, 8'h66, 8'h6c, 8'h78, 8'h00},  // d
    '{8'h7e, 8'h60, 8'h60, 8'h7c, 8'h60, 8'h60, 8'h7e, 8'h00},  // e
    '{8'h7e, 8'h60, 8'h60, 8'h7c, 8'h60, 8'h60, 8'h60, 8'h00}   // f
};

// bottom row is blank on every glyph
// so adjacent text lines never touch

/* verilog/splash_pkg.sv */
//----------------------------------------------------------------------
// shared types and constants of the boot splash overlay
// video pixel, logo download port, raster info and pixel source
// imported by every block of the overlay and by the testbench
//----------------------------------------------------------------------
package splash_pkg;

    // colour depth, fixed since video_t carries it
    localparam int color_w = 4;

    // logo bitmap geometry in screen pixels
    localparam int logo_w = 256;
    localparam int logo_h = 128;

    // one pixel of core video, 16 bits
    typedef struct packed {
        logic [color_w-1:0] red;
        logic [color_w-1:0] green;
        logic [color_w-1:0] blue;
        logic               hs;
        logic               vs;
        logic               lhbl;   // low during horizontal blank
        logic               lvbl;   // low during vertical blank
    } video_t;

    // host write port for the logo RAM
    typedef struct packed {
        logic [10:0] addr;
        logic [7:0]  data;
        logic        we;            // one byte per clk while high
    } prog_t;

    // where an output pixel comes from
    typedef enum logic [1:0] {
        src_video,
        src_logo,
        src_chipid
    } pxl_src_e;

    // counters and centring offsets
    typedef struct packed {
        logic [8:0] hcnt;           // active pixel in line
        logic [8:0] vcnt;           // active line in frame
        logic [8:0] hover;          // left margin of logo
        logic [8:0] vover;          // top margin of logo
    } raster_t;

endpackage

/* verilog/logo_ram.sv */
//----------------------------------------------------------------------
// logo bitmap storage, 2048 bytes, one bit per pixel
// host writes through prog, reads come back one clk later
// contents are undefined until the host has loaded them
//----------------------------------------------------------------------
`timescale 1ns/1ps

module logo_ram (
    input  logic              clk,
    input  splash_pkg::prog_t prog,
    input  logic [10:0]       rd_addr,
    output logic [7:0]        rd_data
);
    import splash_pkg::*;

    // 8 pixels per byte, each stored row covers two screen lines
    localparam int depth = logo_w * logo_h / 16;

    logic [7:0] mem [depth];

    // write side
    always_ff @(posedge clk) begin
        if (prog.we) begin
            mem[prog.addr] <= prog.data;
        end
    end

    // read side, registered
    // a same-address write returns the old byte
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* verilog/raster_measure.sv */
//----------------------------------------------------------------------
// counts active pixels and lines from the blanking signals
// latches the active size each line and frame, then derives the
// offsets that centre the logo on whatever resolution the core uses
//----------------------------------------------------------------------
`timescale 1ns/1ps

module raster_measure (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pxl_cen,
    input  logic                lhbl,
    input  logic                lvbl,
    output splash_pkg::raster_t raster
);
    import splash_pkg::*;

    logic [8:0] hcnt;
    logic [8:0] vcnt;
    logic [8:0] htot;       // active width, last line
    logic [8:0] vtot;       // active height, last frame
    logic [8:0] hover;
    logic [8:0] vover;
    logic       lhbl_l;
    logic       lvbl_l;
    logic       hbl_fall;
    logic       vbl_fall;

    // half of the excess over the logo size, 0 if the screen is smaller
    function automatic logic [8:0] center_off(
        input logic [8:0] tot,
        input logic [8:0] size
    );
        logic [8:0] excess;
        excess = tot - size;
        return (tot < size) ? 9'd0 : (excess >> 1);
    endfunction

    assign hbl_fall = lhbl_l & ~lhbl;   // line just ended
    assign vbl_fall = lvbl_l & ~lvbl;   // frame just ended

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hcnt   <= '0;
            vcnt   <= '0;
            htot   <= '0;
            vtot   <= '0;
            hover  <= '0;
            vover  <= '0;
            lhbl_l <= 1'b0;
            lvbl_l <= 1'b0;
        end else if (pxl_cen) begin
            lhbl_l <= lhbl;
            lvbl_l <= lvbl;
            hcnt   <= lhbl ? hcnt + 9'd1 : 9'd0;
            if (hbl_fall) begin
                htot <= hcnt;
                vcnt <= lvbl ? vcnt + 9'd1 : 9'd0;
            end
            if (vbl_fall) begin
                vtot  <= vcnt;
                // old vtot here, so vover lags one frame
                hover <= center_off(htot, 9'(logo_w));
                vover <= center_off(vtot, 9'(logo_h));
            end
        end
    end

    assign raster = '{
        hcnt:  hcnt,
        vcnt:  vcnt,
        hover: hover,
        vover: vover
    };

endmodule

/* verilog/chipid_render.sv */
//----------------------------------------------------------------------
// draws a 64-bit ID as sixteen hex digits in one 8-line strip
// strip starts at column hex_h0, row hex_v0, most significant first
// purely combinational, pxl follows hcnt and vcnt directly
//----------------------------------------------------------------------
`timescale 1ns/1ps

module chipid_render #(
    parameter bit show_chipid = 1'b1,
    parameter int hex_h0      = 64,
    parameter int hex_v0      = 192
) (
    input  logic [8:0]  hcnt,
    input  logic [8:0]  vcnt,
    input  logic [63:0] chipid,
    output logic        pxl
);
    `include "hex_font.svh"

    logic [9:0] hoff;       // position inside the strip
    logic [9:0] voff;
    logic       in_strip;
    logic [3:0] digit;
    logic [2:0] col;
    logic [2:0] row;
    logic [3:0] nibble;
    logic [7:0] glyph_row;

    // left or above the strip wraps to a large unsigned value
    assign hoff = {1'b0, hcnt} - 10'(hex_h0);
    assign voff = {1'b0, vcnt} - 10'(hex_v0);

    assign in_strip = (hoff < 10'd128) && (voff < 10'd8);   // 16 digits x 8 px

    assign digit = hoff[6:3];
    assign col   = hoff[2:0];
    assign row   = voff[2:0];

    // digit k shows nibble 15-k, and 15-k is ~k on four bits
    assign nibble = chipid[{~digit, 2'b00} +: 4];

    assign glyph_row = hex_font[nibble][row];

    // msb is the leftmost pixel of the glyph
    assign pxl = show_chipid && in_strip && glyph_row[3'd7 - col];

endmodule

/* verilog/logo_overlay.sv */
//----------------------------------------------------------------------
// core video in, overlaid video out, one pixel enable later
// show_en swaps the picture for the logo inside the centred zone
// and for the chip ID text elsewhere, syncs always pass untouched
//----------------------------------------------------------------------
`timescale 1ns/1ps

module logo_overlay #(
    parameter bit show_chipid = 1'b1,
    parameter int hex_h0      = 64,
    parameter int hex_v0      = 192
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                pxl_cen,
    input  logic                show_en,
    input  splash_pkg::video_t  vid_in,
    input  splash_pkg::raster_t raster,
    input  splash_pkg::prog_t   prog,
    input  logic [63:0]         chipid,
    output splash_pkg::video_t  vid_out
);
    import splash_pkg::*;

    logic [9:0]  dx;        // signed, bit 9 set left of the logo
    logic [9:0]  dy;        // signed, bit 9 set above the logo
    logic        in_zone;
    logic [10:0] rd_addr;
    logic [7:0]  rd_data;
    logic        logo_bit;
    logic        id_pxl;
    logic        mono;      // black or white pixel when overlaid
    pxl_src_e    src;
    video_t      vid_nxt;

    logo_ram u_logo_ram (
        .clk     (clk),
        .prog    (prog),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    chipid_render #(
        .show_chipid (show_chipid),
        .hex_h0      (hex_h0),
        .hex_v0      (hex_v0)
    ) u_chipid_render (
        .hcnt   (raster.hcnt),
        .vcnt   (raster.vcnt),
        .chipid (chipid),
        .pxl    (id_pxl)
    );

    assign dx = {1'b0, raster.hcnt} - {1'b0, raster.hover};
    assign dy = {1'b0, raster.vcnt} - {1'b0, raster.vover};

    assign in_zone = !dx[9] && (dx < 10'(logo_w)) &&
                     !dy[9] && (dy < 10'(logo_h));

    // 16-line band picks the 256-byte block, dx the byte
    // RAM answers one clk later, well before the next strobe
    assign rd_addr  = {dy[6:4], dx[7:0]};
    assign logo_bit = rd_data[dy[3:1]];    // each bitmap row shown twice

    always_comb begin
        if (!show_en) begin
            src = src_video;
        end else if (in_zone) begin
            src = src_logo;
        end else begin
            src = src_chipid;
        end
    end

    assign mono = (src == src_logo) ? logo_bit : id_pxl;

    always_comb begin
        vid_nxt = vid_in;               // syncs and blanking as they come
        if (src != src_video) begin
            vid_nxt.red   = {color_w{mono}};
            vid_nxt.green = {color_w{mono}};
            vid_nxt.blue  = {color_w{mono}};
        end
    end

    // one strobe of latency for colour and syncs alike
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vid_out <= '0;
        end else if (pxl_cen) begin
            vid_out <= vid_nxt;
        end
    end

endmodule

/* verilog/logo_splash_top.sv */
//----------------------------------------------------------------------
// boot splash overlay for a retro core video stream
// measures the raster, then overlays the logo or the chip ID
// parameters place the ID text and can switch it off
//----------------------------------------------------------------------
`timescale 1ns/1ps

module logo_splash_top #(
    parameter bit show_chipid = 1'b1,
    parameter int hex_h0      = 64,    // ID text left column
    parameter int hex_v0      = 192    // ID text top line
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               pxl_cen,
    input  logic               show_en,
    input  splash_pkg::video_t vid_in,
    input  splash_pkg::prog_t  prog,
    input  logic [63:0]        chipid,
    output splash_pkg::video_t vid_out
);
    import splash_pkg::*;

    raster_t raster;    // counters and offsets for the overlay

    raster_measure u_raster_measure (
        .clk     (clk),
        .arst_n  (arst_n),
        .pxl_cen (pxl_cen),
        .lhbl    (vid_in.lhbl),
        .lvbl    (vid_in.lvbl),
        .raster  (raster)
    );

    logo_overlay #(
        .show_chipid (show_chipid),
        .hex_h0      (hex_h0),
        .hex_v0      (hex_v0)
    ) u_logo_overlay (
        .clk     (clk),
        .arst_n  (arst_n),
        .pxl_cen (pxl_cen),
        .show_en (show_en),
        .vid_in  (vid_in),
        .raster  (raster),
        .prog    (prog),
        .chipid  (chipid),
        .vid_out (vid_out)
    );

endmodule

/* tests/logo_splash_props.sv */
//----------------------------------------------------------------------
// port level properties of the splash overlay, bound into the top
// sync delay, reset value and output hold between strobes
// each failure bumps fail_cnt, which the testbench watches
//----------------------------------------------------------------------
`timescale 1ns/1ps

module logo_splash_props (
    input logic               clk,
    input logic               arst_n,
    input logic               pxl_cen,
    input splash_pkg::video_t vid_in,
    input splash_pkg::video_t vid_out
);
    import splash_pkg::*;

    int unsigned fail_cnt = 0;  // failed property count
    logic [3:0]  sync_in;
    logic [3:0]  sync_out;

    assign sync_in  = {vid_in.hs, vid_in.vs, vid_in.lhbl, vid_in.lvbl};
    assign sync_out = {vid_out.hs, vid_out.vs, vid_out.lhbl, vid_out.lvbl};

    // syncs and blanking come out one strobe after they go in
    sync_delay: assert property (@(posedge clk) disable iff (!arst_n)
        pxl_cen |=> sync_out == $past(sync_in))
    else begin
        $error("syncs or blanking did not follow the input one strobe later");
        fail_cnt++;
    end

    // all zero right after reset, syncs included
    reset_zero: assert property (@(posedge clk) $rose(arst_n) |-> vid_out == '0)
    else begin
        $error("vid_out was not zero when reset was released");
        fail_cnt++;
    end

    // output only moves on a strobe
    hold_between: assert property (@(posedge clk) disable iff (!arst_n)
        !pxl_cen |=> $stable(vid_out))
    else begin
        $error("vid_out changed on a clock without pxl_cen");
        fail_cnt++;
    end

endmodule

/* tests/logo_splash_tb.sv */
//----------------------------------------------------------------------
// testbench for the boot splash overlay
// runs six 384x240 frames, loads the logo twice, and checks every
// output pixel against a model of the overlay rules, one strobe late
//----------------------------------------------------------------------
`timescale 1ns/1ps

module logo_splash_tb;
    import splash_pkg::*;
    `include "hex_font.svh"

    localparam int act_w     = 320;
    localparam int act_h     = 224;
    localparam int line_w    = act_w + 64;              // 64 blank pixels
    localparam int frame_h   = act_h + 16;              // 16 blank lines
    localparam int n_frames  = 6;
    localparam int id_h0     = 64;
    localparam int id_v0     = 192;
    localparam int exp_hover = (act_w - logo_w) / 2;    // 32
    localparam int exp_vover = (act_h - logo_h) / 2;    // 48
    localparam int n_redl    = 256;                     // bytes of the second load
    localparam int max_cycles = n_frames * line_w * frame_h * 2 + 2048 + n_redl + 2000;

    logic        clk;
    logic        arst_n;
    logic        pxl_cen;
    logic        show_en;
    video_t      vid_in;
    prog_t       prog;
    logic [63:0] chipid;
    video_t      vid_out;

    logic [7:0]  mem_copy [2048];   // every byte written to the RAM
    logic [31:0] rng;
    video_t      exp_d;             // expected output after the next strobe
    video_t      exp_q;
    string       tag_d;
    string       tag_q;
    int          frame_no;
    int          line_no;
    bit          cen_seen;
    int          cycle_cnt;

    logo_splash_top #(
        .show_chipid (1'b1),
        .hex_h0      (id_h0),
        .hex_v0      (id_v0)
    ) u_logo_splash_top (
        .clk     (clk),
        .arst_n  (arst_n),
        .pxl_cen (pxl_cen),
        .show_en (show_en),
        .vid_in  (vid_in),
        .prog    (prog),
        .chipid  (chipid),
        .vid_out (vid_out)
    );

    bind logo_splash_top logo_splash_props u_logo_splash_props (
        .clk     (clk),
        .arst_n  (arst_n),
        .pxl_cen (pxl_cen),
        .vid_in  (vid_in),
        .vid_out (vid_out)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;          // 20 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // logo bit at raster position h, v, or -1 outside the centred zone
    function automatic int logo_pixel(input int h, input int v);
        int dx;
        int dy;
        dx = h - exp_hover;
        dy = v - exp_vover;
        if (dx < 0 || dx >= logo_w || dy < 0 || dy >= logo_h) begin
            return -1;
        end
        return int'(mem_copy[(dy / 16) * 256 + dx][(dy / 2) % 8]);  // rows doubled
    endfunction

    // glyph bit of the ID strip, 0 outside it
    function automatic bit id_pixel(input int h, input int v);
        int         k;
        logic [3:0] nib;
        logic [7:0] glyph;
        if (h < id_h0 || h >= id_h0 + 128 || v < id_v0 || v >= id_v0 + 8) begin
            return 1'b0;
        end
        k     = (h - id_h0) / 8;
        nib   = chipid[(15 - k) * 4 +: 4];      // digit 0 is the top nibble
        glyph = hex_font[nib][v - id_v0];
        return glyph[7 - (h - id_h0) % 8];
    endfunction

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // one pixel per two clocks, model value set up for the same strobe
    task automatic drive_pixel(input int x, input int y);
        video_t v;
        int     lb;
        bit     mono;
        v.red   = 4'(x + frame_no);
        v.green = 4'(y);
        v.blue  = 4'(x ^ y);
        v.hs    = !(x >= 336 && x < 368);
        v.vs    = !(y >= 228 && y < 231);
        v.lhbl  = (x < act_w);
        v.lvbl  = (y < act_h);
        exp_d   = v;                            // syncs always pass through
        tag_d   = "passthrough";
        if (show_en) begin
            lb = logo_pixel(x, y);
            if (lb >= 0) begin
                mono  = lb[0];
                tag_d = "logo";
                if (frame_no == 4) begin
                    tag_d = "redownload";       // frame after the second load
                end
            end else begin
                mono  = id_pixel(x, y);
                tag_d = (y >= id_v0 && y < id_v0 + 8) ? "chipid" : "black";
            end
            exp_d.red   = {color_w{mono}};
            exp_d.green = {color_w{mono}};
            exp_d.blue  = {color_w{mono}};
        end
        @(negedge clk);
        vid_in  = v;
        pxl_cen = 1'b1;
        @(negedge clk);
        pxl_cen = 1'b0;
    endtask

    task automatic run_frames();
        for (int f = 0; f < n_frames; f++) begin
            frame_no = f;
            show_en  = (f >= 2 && f <= 4);      // offsets settle after frame 1
            for (int y = 0; y < frame_h; y++) begin
                line_no = y;
                for (int x = 0; x < line_w; x++) begin
                    drive_pixel(x, y);
                end
            end
        end
    endtask

    // sequential or scattered addresses, random bytes
    task automatic download(input int count, input bit scatter);
        logic [10:0] a;
        for (int i = 0; i < count; i++) begin
            rng = xorshift32(rng);
            a   = scatter ? rng[26:16] : 11'(i);
            @(negedge clk);
            prog.addr   = a;
            prog.data   = rng[7:0];
            prog.we     = 1'b1;
            mem_copy[a] = rng[7:0];
        end
        @(negedge clk);
        prog.we = 1'b0;
    endtask

    // model output register, one strobe like the DUT
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_q <= '0;
            tag_q <= "reset";
        end else if (pxl_cen) begin
            exp_q    <= exp_d;
            tag_q    <= tag_d;
            cen_seen <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout, frames not finished after %0d cycles", max_cycles);
            abort_run();
        end
    end

    always @(negedge clk) begin
        if (u_logo_splash_top.u_logo_splash_props.fail_cnt != 0) begin
            $display("a bound property on the DUT ports failed");
            abort_run();
        end
    end

    // sampled on the falling edge, where vid_out and the model are stable
    check_reset: assert property (@(negedge clk) disable iff (!arst_n)
        !cen_seen |-> vid_out == '0)
    else begin
        $display("mismatch reset expected %h actual %h", 16'h0, vid_out);
        abort_run();
    end

    check_color: assert property (@(negedge clk) disable iff (!arst_n)
        {vid_out.red, vid_out.green, vid_out.blue} == {exp_q.red, exp_q.green, exp_q.blue})
    else begin
        $display("mismatch %s expected %h actual %h", tag_q,
                 {exp_q.red, exp_q.green, exp_q.blue},
                 {vid_out.red, vid_out.green, vid_out.blue});
        abort_run();
    end

    check_syncs: assert property (@(negedge clk) disable iff (!arst_n)
        {vid_out.hs, vid_out.vs, vid_out.lhbl, vid_out.lvbl} ==
        {exp_q.hs, exp_q.vs, exp_q.lhbl, exp_q.lvbl})
    else begin
        $display("mismatch syncs expected %b actual %b",
                 {exp_q.hs, exp_q.vs, exp_q.lhbl, exp_q.lvbl},
                 {vid_out.hs, vid_out.vs, vid_out.lhbl, vid_out.lvbl});
        abort_run();
    end

    initial begin
        arst_n    = 1'b0;
        pxl_cen   = 1'b0;
        show_en   = 1'b0;
        vid_in    = '0;
        prog      = '0;
        cen_seen  = 1'b0;
        cycle_cnt = 0;
        frame_no  = 0;
        line_no   = 0;
        exp_d     = '0;
        tag_d     = "reset";
        rng       = 32'd68;
        rng       = xorshift32(rng);
        chipid[63:32] = rng;
        rng       = xorshift32(rng);
        chipid[31:0]  = rng;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);              // idle, output stays zero
        fork
            run_frames();
            begin
                download(2048, 1'b0);           // whole bitmap during frame 0
                wait (frame_no == 3 && line_no == act_h + 1);
                download(n_redl, 1'b1);         // vertical blank of frame 3
            end
        join
        repeat (4) @(negedge clk);
        if (u_logo_splash_top.u_logo_splash_props.fail_cnt != 0) begin
            $display("bound properties reported failures");
            abort_run();
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

/* logo_splash.f */
+incdir+include
verilog/splash_pkg.sv
verilog/logo_ram.sv
verilog/raster_measure.sv
verilog/chipid_render.sv
verilog/logo_overlay.sv
verilog/logo_splash_top.sv
tests/logo_splash_props.sv
tests/logo_splash_tb.sv
